//--- axi_pkg.sv
package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    typedef logic [ADDR_W-1:0] addr_t;  // byte address
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;  // one bit per byte lane
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [1:0]        resp_t;

    // subset of the AXI response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

endpackage

//--- mem_pkg.sv
package mem_pkg;

    // default SRAM window
    localparam logic [31:0] MEM_BASE_DEFAULT  = 32'h8000_0000;
    localparam int          MEM_WORDS_DEFAULT = 1024;  // 4 KiB

    localparam int WORD_IDX_W = $clog2(MEM_WORDS_DEFAULT);

    // word index inside the default window
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

endpackage

//--- axi_if.sv
`timescale 1ns/1ns

interface axi_if;

    // write address
    logic           awvalid;
    logic           awready;
    axi_pkg::addr_t awaddr;
    axi_pkg::id_t   awid;

    // write data, single beat
    logic           wvalid;
    logic           wready;
    axi_pkg::data_t wdata;
    axi_pkg::strb_t wstrb;

    // write response
    logic           bvalid;
    logic           bready;
    axi_pkg::resp_t bresp;
    axi_pkg::id_t   bid;

    // read address
    logic           arvalid;
    logic           arready;
    axi_pkg::addr_t araddr;
    axi_pkg::id_t   arid;

    // read data, always last
    logic           rvalid;
    logic           rready;
    axi_pkg::data_t rdata;
    axi_pkg::resp_t rresp;
    axi_pkg::id_t   rid;

    modport master (
        output awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
        output arvalid, araddr, arid, rready,
        input  awready, wready, bvalid, bresp, bid, arready, rvalid, rdata, rresp, rid
    );

    modport slave (
        input  awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
        input  arvalid, araddr, arid, rready,
        output awready, wready, bvalid, bresp, bid, arready, rvalid, rdata, rresp, rid
    );

endinterface

//--- axi_sram.sv
`timescale 1ns/1ns

module axi_sram #(
    parameter axi_pkg::addr_t MEM_BASE  = mem_pkg::MEM_BASE_DEFAULT,
    parameter int             MEM_WORDS = mem_pkg::MEM_WORDS_DEFAULT
) (
    input  logic  clk,
    input  logic  rst,
    axi_if.slave  s
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    typedef enum logic {IDLE, BUSY} state_t;

    state_t           state;
    logic             req_is_read;
    logic             rvalid_q;
    logic             bvalid_q;

    // latched request
    axi_pkg::addr_t   req_addr;
    axi_pkg::id_t     req_id;
    axi_pkg::data_t   req_data;
    axi_pkg::strb_t   req_strb;

    axi_pkg::data_t   rdata_q;
    axi_pkg::resp_t   resp_q;

    axi_pkg::data_t   mem [MEM_WORDS];

    logic             idle;
    logic             rd_accept;
    logic             wr_accept;
    logic             access;
    logic             rsp_done;
    axi_pkg::addr_t   offset;
    logic [31:0]      word_num;
    logic             in_range;
    logic [IDX_W-1:0] word_idx;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign idle      = (state == IDLE);
    assign rd_accept = idle && s.arvalid;  // reads win a same-cycle tie
    assign wr_accept = idle && !s.arvalid && s.awvalid && s.wvalid;
    assign access    = (state == BUSY) && !rvalid_q && !bvalid_q;  // first BUSY cycle
    assign rsp_done  = (rvalid_q && s.rready) || (bvalid_q && s.bready);

    // address decode, low two bits dropped
    assign offset   = req_addr - MEM_BASE;
    assign word_num = {2'b00, offset[31:2]};
    assign in_range = (word_num < 32'(MEM_WORDS));
    assign word_idx = word_num[IDX_W-1:0];

    assign s.arready = idle;
    assign s.awready = idle && !s.arvalid;
    assign s.wready  = idle && !s.arvalid;

    assign s.rvalid = rvalid_q;
    assign s.rdata  = rdata_q;
    assign s.rresp  = resp_q;
    assign s.rid    = req_id;
    assign s.bvalid = bvalid_q;
    assign s.bresp  = resp_q;
    assign s.bid    = req_id;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            req_is_read <= 1'b0;
            rvalid_q    <= 1'b0;
            bvalid_q    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_accept || wr_accept) begin
                        state       <= BUSY;
                        req_is_read <= rd_accept;
                    end
                end
                BUSY: begin
                    if (access) begin
                        rvalid_q <= req_is_read;
                        bvalid_q <= !req_is_read;
                    end else if (rsp_done) begin
                        rvalid_q <= 1'b0;
                        bvalid_q <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            req_addr <= s.araddr;
            req_id   <= s.arid;
        end else if (wr_accept) begin
            req_addr <= s.awaddr;
            req_id   <= s.awid;
            req_data <= s.wdata;
            req_strb <= s.wstrb;
        end
    end

    // array access, one cycle after accept
    always_ff @(posedge clk) begin
        if (access) begin
            resp_q <= in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_DECERR;
            if (req_is_read) begin
                rdata_q <= in_range ? mem[word_idx] : '0;
            end else if (in_range) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_strb[b]) begin
                        mem[word_idx][8*b +: 8] <= req_data[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- axi_arbiter.sv
`timescale 1ns/1ns

module axi_arbiter (
    input  logic  clk,
    input  logic  rst,
    axi_if.slave  m0,
    axi_if.slave  m1,
    axi_if.master s
);

    logic [1:0] grant;     // one-hot, zero when idle
    logic       last_sel;  // 1 = m1 won last time
    logic       m0_req;
    logic       m1_req;
    logic       winner;
    logic       sel;
    logic       rsp_done;

    assign m0_req = m0.arvalid || m0.awvalid;
    assign m1_req = m1.arvalid || m1.awvalid;

    // round robin on a tie
    always_comb begin
        if (m0_req && m1_req) begin
            winner = !last_sel;
        end else begin
            winner = m1_req;
        end
    end

    assign sel      = grant[1];
    assign rsp_done = (s.rvalid && s.rready) || (s.bvalid && s.bready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant    <= 2'b00;
            last_sel <= 1'b1;  // m0 takes the first tie
        end else if (grant == 2'b00) begin
            if (m0_req || m1_req) begin
                grant    <= winner ? 2'b10 : 2'b01;
                last_sel <= winner;
            end
        end else if (rsp_done) begin
            grant <= 2'b00;
        end
    end

    // request channels to the slave
    assign s.awvalid = (grant[0] && m0.awvalid) || (grant[1] && m1.awvalid);
    assign s.awaddr  = sel ? m1.awaddr : m0.awaddr;
    assign s.awid    = sel ? m1.awid : m0.awid;
    assign s.wvalid  = (grant[0] && m0.wvalid) || (grant[1] && m1.wvalid);
    assign s.wdata   = sel ? m1.wdata : m0.wdata;
    assign s.wstrb   = sel ? m1.wstrb : m0.wstrb;
    assign s.arvalid = (grant[0] && m0.arvalid) || (grant[1] && m1.arvalid);
    assign s.araddr  = sel ? m1.araddr : m0.araddr;
    assign s.arid    = sel ? m1.arid : m0.arid;
    assign s.bready  = (grant[0] && m0.bready) || (grant[1] && m1.bready);
    assign s.rready  = (grant[0] && m0.rready) || (grant[1] && m1.rready);

    // m0 side, ready and valid only while granted
    assign m0.awready = grant[0] && s.awready;
    assign m0.wready  = grant[0] && s.wready;
    assign m0.arready = grant[0] && s.arready;
    assign m0.bvalid  = grant[0] && s.bvalid;
    assign m0.bresp   = s.bresp;
    assign m0.bid     = s.bid;
    assign m0.rvalid  = grant[0] && s.rvalid;
    assign m0.rdata   = s.rdata;
    assign m0.rresp   = s.rresp;
    assign m0.rid     = s.rid;

    // m1 side
    assign m1.awready = grant[1] && s.awready;
    assign m1.wready  = grant[1] && s.wready;
    assign m1.arready = grant[1] && s.arready;
    assign m1.bvalid  = grant[1] && s.bvalid;
    assign m1.bresp   = s.bresp;
    assign m1.bid     = s.bid;
    assign m1.rvalid  = grant[1] && s.rvalid;
    assign m1.rdata   = s.rdata;
    assign m1.rresp   = s.rresp;
    assign m1.rid     = s.rid;

endmodule

//--- mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top #(
    parameter axi_pkg::addr_t MEM_BASE  = mem_pkg::MEM_BASE_DEFAULT,
    parameter int             MEM_WORDS = mem_pkg::MEM_WORDS_DEFAULT
) (
    input  logic           clk,
    input  logic           rst,
    // fetch master
    input  logic           m0_awvalid,
    output logic           m0_awready,
    input  axi_pkg::addr_t m0_awaddr,
    input  axi_pkg::id_t   m0_awid,
    input  logic           m0_wvalid,
    output logic           m0_wready,
    input  axi_pkg::data_t m0_wdata,
    input  axi_pkg::strb_t m0_wstrb,
    output logic           m0_bvalid,
    input  logic           m0_bready,
    output axi_pkg::resp_t m0_bresp,
    output axi_pkg::id_t   m0_bid,
    input  logic           m0_arvalid,
    output logic           m0_arready,
    input  axi_pkg::addr_t m0_araddr,
    input  axi_pkg::id_t   m0_arid,
    output logic           m0_rvalid,
    input  logic           m0_rready,
    output axi_pkg::data_t m0_rdata,
    output axi_pkg::resp_t m0_rresp,
    output axi_pkg::id_t   m0_rid,
    // load/store master
    input  logic           m1_awvalid,
    output logic           m1_awready,
    input  axi_pkg::addr_t m1_awaddr,
    input  axi_pkg::id_t   m1_awid,
    input  logic           m1_wvalid,
    output logic           m1_wready,
    input  axi_pkg::data_t m1_wdata,
    input  axi_pkg::strb_t m1_wstrb,
    output logic           m1_bvalid,
    input  logic           m1_bready,
    output axi_pkg::resp_t m1_bresp,
    output axi_pkg::id_t   m1_bid,
    input  logic           m1_arvalid,
    output logic           m1_arready,
    input  axi_pkg::addr_t m1_araddr,
    input  axi_pkg::id_t   m1_arid,
    output logic           m1_rvalid,
    input  logic           m1_rready,
    output axi_pkg::data_t m1_rdata,
    output axi_pkg::resp_t m1_rresp,
    output axi_pkg::id_t   m1_rid
);

    axi_if m0_bus ();
    axi_if m1_bus ();
    axi_if sram_bus ();  // arbiter to SRAM

    assign m0_bus.awvalid = m0_awvalid;
    assign m0_bus.awaddr  = m0_awaddr;
    assign m0_bus.awid    = m0_awid;
    assign m0_bus.wvalid  = m0_wvalid;
    assign m0_bus.wdata   = m0_wdata;
    assign m0_bus.wstrb   = m0_wstrb;
    assign m0_bus.bready  = m0_bready;
    assign m0_bus.arvalid = m0_arvalid;
    assign m0_bus.araddr  = m0_araddr;
    assign m0_bus.arid    = m0_arid;
    assign m0_bus.rready  = m0_rready;
    assign m0_awready     = m0_bus.awready;
    assign m0_wready      = m0_bus.wready;
    assign m0_bvalid      = m0_bus.bvalid;
    assign m0_bresp       = m0_bus.bresp;
    assign m0_bid         = m0_bus.bid;
    assign m0_arready     = m0_bus.arready;
    assign m0_rvalid      = m0_bus.rvalid;
    assign m0_rdata       = m0_bus.rdata;
    assign m0_rresp       = m0_bus.rresp;
    assign m0_rid         = m0_bus.rid;

    assign m1_bus.awvalid = m1_awvalid;
    assign m1_bus.awaddr  = m1_awaddr;
    assign m1_bus.awid    = m1_awid;
    assign m1_bus.wvalid  = m1_wvalid;
    assign m1_bus.wdata   = m1_wdata;
    assign m1_bus.wstrb   = m1_wstrb;
    assign m1_bus.bready  = m1_bready;
    assign m1_bus.arvalid = m1_arvalid;
    assign m1_bus.araddr  = m1_araddr;
    assign m1_bus.arid    = m1_arid;
    assign m1_bus.rready  = m1_rready;
    assign m1_awready     = m1_bus.awready;
    assign m1_wready      = m1_bus.wready;
    assign m1_bvalid      = m1_bus.bvalid;
    assign m1_bresp       = m1_bus.bresp;
    assign m1_bid         = m1_bus.bid;
    assign m1_arready     = m1_bus.arready;
    assign m1_rvalid      = m1_bus.rvalid;
    assign m1_rdata       = m1_bus.rdata;
    assign m1_rresp       = m1_bus.rresp;
    assign m1_rid         = m1_bus.rid;

    axi_arbiter u_arbiter (
        .clk (clk),
        .rst (rst),
        .m0  (m0_bus.slave),
        .m1  (m1_bus.slave),
        .s   (sram_bus.master)
    );

    axi_sram #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clk (clk),
        .rst (rst),
        .s   (sram_bus.slave)
    );

endmodule

//--- tb_mem_subsys.sv
`timescale 1ns/1ns

module tb_mem_subsys;

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] MEM_BASE   = 32'h8000_0000;
    localparam int          MEM_WORDS  = 1024;
    localparam int          TXNS       = 69;  // transactions over all tests

    logic        clk = 1'b0;
    logic        rst;
    logic        awvalid [2], wvalid [2], bready [2], arvalid [2], rready [2];
    logic        awready [2], wready [2], bvalid [2], arready [2], rvalid [2];
    logic [31:0] awaddr [2], araddr [2], wdata [2], rdata [2];
    logic [3:0]  awid [2], arid [2], bid [2], rid [2], wstrb [2];
    logic [1:0]  bresp [2], rresp [2];

    logic [31:0] ref_mem [MEM_WORDS];  // expected SRAM contents
    int          done_order [$];       // master of each finished transaction
    int          seed = 32'hc6ad_7c7d;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          start_errs;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_subsys_top dut (
        .clk        (clk),         .rst        (rst),
        .m0_awvalid (awvalid[0]),  .m1_awvalid (awvalid[1]),
        .m0_awready (awready[0]),  .m1_awready (awready[1]),
        .m0_awaddr  (awaddr[0]),   .m1_awaddr  (awaddr[1]),
        .m0_awid    (awid[0]),     .m1_awid    (awid[1]),
        .m0_wvalid  (wvalid[0]),   .m1_wvalid  (wvalid[1]),
        .m0_wready  (wready[0]),   .m1_wready  (wready[1]),
        .m0_wdata   (wdata[0]),    .m1_wdata   (wdata[1]),
        .m0_wstrb   (wstrb[0]),    .m1_wstrb   (wstrb[1]),
        .m0_bvalid  (bvalid[0]),   .m1_bvalid  (bvalid[1]),
        .m0_bready  (bready[0]),   .m1_bready  (bready[1]),
        .m0_bresp   (bresp[0]),    .m1_bresp   (bresp[1]),
        .m0_bid     (bid[0]),      .m1_bid     (bid[1]),
        .m0_arvalid (arvalid[0]),  .m1_arvalid (arvalid[1]),
        .m0_arready (arready[0]),  .m1_arready (arready[1]),
        .m0_araddr  (araddr[0]),   .m1_araddr  (araddr[1]),
        .m0_arid    (arid[0]),     .m1_arid    (arid[1]),
        .m0_rvalid  (rvalid[0]),   .m1_rvalid  (rvalid[1]),
        .m0_rready  (rready[0]),   .m1_rready  (rready[1]),
        .m0_rdata   (rdata[0]),    .m1_rdata   (rdata[1]),
        .m0_rresp   (rresp[0]),    .m1_rresp   (rresp[1]),
        .m0_rid     (rid[0]),      .m1_rid     (rid[1])
    );

    function automatic logic in_window(logic [31:0] addr);
        return (addr >= MEM_BASE) && (addr < MEM_BASE + 4 * MEM_WORDS);
    endfunction

    function automatic logic [1:0] exp_resp(logic [31:0] addr);
        return in_window(addr) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_DECERR;
    endfunction

    function automatic logic [31:0] model_read(logic [31:0] addr);
        logic [31:0] off;
        off = addr - MEM_BASE;
        return in_window(addr) ? ref_mem[off >> 2] : 32'h0;  // low bits ignored
    endfunction

    task automatic model_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
        logic [31:0] off;
        off = addr - MEM_BASE;
        if (in_window(addr)) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    ref_mem[off >> 2][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic no_response_check(int m);
        checks++;
        if (bvalid[m] || rvalid[m]) begin
            errors++;
            $display("t=%0t m%0d got a response while the other one was held", $time, m);
        end
    endtask

    task automatic write_rsp_check(int m, logic [1:0] resp, logic [3:0] id);
        compare($sformatf("m%0d_bvalid", m), 1, bvalid[m]);
        compare($sformatf("m%0d_bresp", m), resp, bresp[m]);
        compare($sformatf("m%0d_bid", m), id, bid[m]);
    endtask

    task automatic read_rsp_check(int m, logic [31:0] data, logic [1:0] resp, logic [3:0] id);
        compare($sformatf("m%0d_rvalid", m), 1, rvalid[m]);
        compare($sformatf("m%0d_rdata", m), data, rdata[m]);
        compare($sformatf("m%0d_rresp", m), resp, rresp[m]);
        compare($sformatf("m%0d_rid", m), id, rid[m]);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after one
    // hold > 0 keeps bready low for that many cycles once bvalid is up
    task automatic axi_write(int m, logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                             logic [3:0] id, int hold = 0);
        awvalid[m] = 1'b1;
        awaddr[m]  = addr;
        awid[m]    = id;
        wvalid[m]  = 1'b1;
        wdata[m]   = data;
        wstrb[m]   = strb;
        bready[m]  = (hold == 0);
        do @(negedge clk); while (!(awready[m] && wready[m]));
        @(posedge clk);
        #1;
        awvalid[m] = 1'b0;
        wvalid[m]  = 1'b0;
        compare($sformatf("m%0d_awready", m), 0, awready[m]);  // slave busy now
        compare($sformatf("m%0d_wready", m), 0, wready[m]);
        do @(negedge clk); while (!bvalid[m]);
        write_rsp_check(m, exp_resp(addr), id);
        repeat (hold) begin
            @(posedge clk);
            #1;
            write_rsp_check(m, exp_resp(addr), id);  // must not move
            no_response_check(1 - m);
        end
        bready[m] = 1'b1;
        @(posedge clk);
        #1;
        model_write(addr, data, strb);
        done_order.push_back(m);
    endtask

    task automatic axi_read(int m, logic [31:0] addr, logic [3:0] id, int hold = 0);
        logic [31:0] exp_data;
        arvalid[m] = 1'b1;
        araddr[m]  = addr;
        arid[m]    = id;
        rready[m]  = (hold == 0);
        do @(negedge clk); while (!arready[m]);
        @(posedge clk);
        #1;
        arvalid[m] = 1'b0;
        compare($sformatf("m%0d_arready", m), 0, arready[m]);
        do @(negedge clk); while (!rvalid[m]);
        exp_data = model_read(addr);
        read_rsp_check(m, exp_data, exp_resp(addr), id);
        repeat (hold) begin
            @(posedge clk);
            #1;
            read_rsp_check(m, exp_data, exp_resp(addr), id);
            no_response_check(1 - m);
        end
        rready[m] = 1'b1;
        @(posedge clk);
        #1;
        done_order.push_back(m);
    endtask

    task automatic test_done(string name);
        tests++;
        $display("test %-12s done, %0d errors", name, errors - start_errs);
    endtask

    task automatic full_word_test();
        start_errs = errors;
        axi_write(0, MEM_BASE + 32'h10, 32'hdead_beef, 4'hf, 4'h3);
        axi_read(1, MEM_BASE + 32'h10, 4'h5);
        test_done("full_word");
    endtask

    task automatic strobe_test();
        logic [31:0] a;
        a = MEM_BASE + 32'h40;
        start_errs = errors;
        axi_write(0, a, 32'h1122_3344, 4'hf, 4'h1);
        axi_read(1, a, 4'h2);
        axi_write(1, a, 32'haaaa_aaaa, 4'b0001, 4'h3);
        axi_read(0, a, 4'h4);
        axi_write(0, a, 32'hbbbb_bbbb, 4'b0110, 4'h5);
        axi_read(1, a, 4'h6);
        axi_write(1, a, 32'hcccc_cccc, 4'b1000, 4'h7);
        axi_read(0, a, 4'h8);
        axi_read(1, a + 3, 4'h9);  // unaligned, whole word back
        test_done("strobe");
    endtask

    task automatic decode_test();
        logic [31:0] top;
        top = MEM_BASE + 4 * (MEM_WORDS - 1);
        start_errs = errors;
        axi_write(1, top, 32'h5a5a_a5a5, 4'hf, 4'h1);
        axi_write(0, MEM_BASE - 4, 32'hffff_ffff, 4'hf, 4'h2);  // would alias the top word
        axi_write(1, MEM_BASE + 4 * MEM_WORDS, 32'hffff_ffff, 4'hf, 4'h3);
        axi_read(0, MEM_BASE - 4, 4'h4);
        axi_read(1, MEM_BASE + 4 * MEM_WORDS, 4'h5);
        axi_read(0, top, 4'h6);
        test_done("decode");
    endtask

    task automatic contention_test();
        logic [31:0] base;
        logic [31:0] d [4];
        base = MEM_BASE + 32'h200;
        start_errs = errors;
        done_order.delete();
        for (int r = 0; r < 4; r++) begin
            d[r] = $random(seed);
        end
        // each master re-requests right away, so every grant is a tie
        fork
            for (int r = 0; r < 4; r++) begin
                axi_write(0, base + 4 * r, d[r], 4'hf, 4'(r));
            end
            for (int r = 0; r < 4; r++) begin
                axi_read(1, base + 4 * r - 4, 4'(8 + r));  // word from the last round
            end
        join
        for (int i = 1; i < done_order.size(); i++) begin
            checks++;
            if (done_order[i] == done_order[i - 1]) begin
                errors++;
                $display("t=%0t m%0d finished twice in a row while the other master waited",
                         $time, done_order[i]);
            end
        end
        test_done("contention");
    endtask

    task automatic backpressure_test();
        start_errs = errors;
        fork
            axi_read(0, MEM_BASE + 32'h10, 4'h9, 8);
            begin
                @(posedge clk);
                #1;
                axi_write(1, MEM_BASE + 32'h20, 32'h1234_5678, 4'hf, 4'ha);
            end
        join
        fork
            axi_write(1, MEM_BASE + 32'h24, 32'h8765_4321, 4'hf, 4'hb, 8);
            begin
                @(posedge clk);
                #1;
                axi_read(0, MEM_BASE + 32'h20, 4'hc);
            end
        join
        test_done("backpressure");
    endtask

    task automatic random_test();
        int          m;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [3:0]  id;
        start_errs = errors;
        repeat (40) begin
            m    = $random(seed) & 1;
            addr = MEM_BASE + 4 * ($unsigned($random(seed)) % MEM_WORDS);
            data = $random(seed);
            strb = $random(seed);
            id   = $random(seed);
            if ($random(seed) & 1) begin
                axi_write(m, addr, data, strb, id);
            end else begin
                axi_read(m, addr, id);
            end
        end
        test_done("random");
    endtask

    // watchdog, 40 cycles per transaction plus reset
    initial begin
        #((TXNS * 40 + 10) * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", TXNS * 40 + 10);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int m = 0; m < 2; m++) begin
            awvalid[m] = 1'b0;
            awaddr[m]  = '0;
            awid[m]    = '0;
            wvalid[m]  = 1'b0;
            wdata[m]   = '0;
            wstrb[m]   = '0;
            bready[m]  = 1'b0;
            arvalid[m] = 1'b0;
            araddr[m]  = '0;
            arid[m]    = '0;
            rready[m]  = 1'b0;
        end
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        full_word_test();
        strobe_test();
        decode_test();
        contention_test();
        backpressure_test();
        random_test();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
axi_pkg.sv
mem_pkg.sv
axi_if.sv
axi_sram.sv
axi_arbiter.sv
mem_subsys_top.sv
tb_mem_subsys.sv
